/* verilog/icache_defs.svh */
// cache geometry and reset constants, included by the packages and the RTL that sizes from them
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

////////////////////
// geometry
////////////////////

// associativity, number of parallel ways
`define ICACHE_WAYS 4
// number of sets, also the number of flush cycles
`define ICACHE_SETS 16
// one cache line, the refill unit
`define ICACHE_LINE_BITS 128
// one fetch word
`define ICACHE_WORD_BITS 32
// physical fetch address
`define ICACHE_ADDR_BITS 16

////////////////////
// replacement
////////////////////

// reset value of the victim LFSR, must be non-zero
`define ICACHE_LFSR_SEED 8'hA5

`endif

/* verilog/icache_addr_pkg.sv */
// address field types of the instruction cache, imported by every block that slices a fetch address
package icache_addr_pkg;

`include "icache_defs.svh"

  ////////////////////
  // address fields
  ////////////////////

  // full physical fetch address
  typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;

  // byte offset inside one line
  typedef logic [$clog2(`ICACHE_LINE_BITS / 8)-1:0] offset_t;

  // set number
  typedef logic [$clog2(`ICACHE_SETS)-1:0] index_t;

  // what is left above index and offset
  typedef logic [`ICACHE_ADDR_BITS-$bits(index_t)-$bits(offset_t)-1:0] tag_t;

  // the same address split into its fields, msb first
  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } addr_fields_t;

endpackage

/* verilog/icache_data_pkg.sv */
// payload types of the instruction cache, words, lines, way numbers and the tag entry
package icache_data_pkg;

`include "icache_defs.svh"

  import icache_addr_pkg::*;

  // number of address bits that pick a word inside a line
  localparam int unsigned WORD_SEL_BITS = $clog2(`ICACHE_LINE_BITS / `ICACHE_WORD_BITS);

  typedef logic [`ICACHE_WORD_BITS-1:0] word_t;
  typedef logic [`ICACHE_LINE_BITS-1:0] line_t;

  // binary way number and one-hot way mask
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]         way_oh_t;

  // one entry of the tag memory, valid bit on top
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // pick the fetch word addressed by offset out of a line
  function automatic word_t word_of_line(line_t line, offset_t offset);
    logic [WORD_SEL_BITS-1:0] sel;
    sel = offset[$bits(offset_t)-1 -: WORD_SEL_BITS];
    return line[sel * `ICACHE_WORD_BITS +: `ICACHE_WORD_BITS];
  endfunction

endpackage

/* verilog/icache_array_if.sv */
// bundle between the cache controller and the way arrays, instantiated once in the cache top
`timescale 1ns/1ps

interface icache_array_if
  import icache_addr_pkg::*;
  import icache_data_pkg::*;
();

  // array commands, at most one of rd/wr/clr per cycle
  logic    rd_en;
  logic    wr_en;
  logic    clr_en;
  // compare result is wanted this cycle
  logic    cmp_en;

  // set to access, and tag/offset of the request in compare
  index_t  index;
  tag_t    tag;
  offset_t offset;
  // refill line to store in the victim way
  line_t   wline;

  // lookup result
  logic    hit;
  word_t   hit_word;

  modport ctrl (
    output rd_en, wr_en, clr_en, cmp_en, index, tag, offset, wline,
    input  hit, hit_word
  );

  modport ways (
    input  rd_en, wr_en, clr_en, cmp_en, index, tag, offset, wline,
    output hit, hit_word
  );

endinterface

/* verilog/icache_sram.sv */
// single-port memory with registered read, used for both the tag and the data array of a way
`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_sram
  import icache_addr_pkg::*;
#(
  parameter int unsigned DEPTH     = `ICACHE_SETS,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // access strobe, write when we_i is also high
  input  logic     req_i,
  input  logic     we_i,
  input  index_t   addr_i,
  input  payload_t wdata_i,
  // read data, one cycle after the read strobe
  output payload_t rdata_o
);

  // storage array
  payload_t mem_q [DEPTH];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  ////////////////////
  // read register
  ////////////////////

  // holds its value while no read is issued
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

/* verilog/icache_ways.sv */
// way arrays of the instruction cache with tag compare, word select and victim choice
`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_ways
  import icache_data_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  icache_array_if.ways arr
);

  // array outputs per way
  tag_entry_t tag_rdata  [`ICACHE_WAYS];
  line_t      line_rdata [`ICACHE_WAYS];

  // array strobes per way
  way_oh_t    tag_req;
  way_oh_t    data_req;
  logic       tag_we;
  tag_entry_t tag_wdata;

  // compare results
  way_oh_t    hit_oh;
  way_oh_t    valid_vec;
  way_idx_t   hit_idx;

  // replacement
  way_idx_t   inv_idx;
  way_idx_t   victim_idx;
  way_oh_t    victim_oh_q;
  logic       all_valid;
  logic       all_valid_q;
  logic [7:0] lfsr_q;
  logic       lfsr_step;

  ////////////////////
  // array control
  ////////////////////

  // a clear writes an all-zero entry, a refill a valid one with the request tag
  assign tag_we    = arr.clr_en | arr.wr_en;
  assign tag_wdata = arr.clr_en ? tag_entry_t'('0) : '{valid: 1'b1, tag: arr.tag};

  for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : gen_way
    // reads and clears touch every way, refills only the victim
    assign tag_req[i]  = arr.rd_en | arr.clr_en | (arr.wr_en & victim_oh_q[i]);
    assign data_req[i] = arr.rd_en | (arr.wr_en & victim_oh_q[i]);

    icache_sram #(
      .DEPTH     (`ICACHE_SETS),
      .payload_t (tag_entry_t)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req[i]),
      .we_i    (tag_we),
      .addr_i  (arr.index),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[i])
    );

    icache_sram #(
      .DEPTH     (`ICACHE_SETS),
      .payload_t (line_t)
    ) i_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (data_req[i]),
      .we_i    (arr.wr_en),
      .addr_i  (arr.index),
      .wdata_i (arr.wline),
      .rdata_o (line_rdata[i])
    );

    // tag compare against the request in compare
    assign valid_vec[i] = tag_rdata[i].valid;
    assign hit_oh[i]    = tag_rdata[i].valid & (tag_rdata[i].tag == arr.tag);
  end

  ////////////////////
  // hit and victim
  ////////////////////

  // lowest hitting way and lowest invalid way
  always_comb begin
    hit_idx = '0;
    inv_idx = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (hit_oh[i]) begin
        hit_idx = way_idx_t'(i);
      end
      if (!valid_vec[i]) begin
        inv_idx = way_idx_t'(i);
      end
    end
  end

  assign arr.hit      = arr.cmp_en & (|hit_oh);
  assign arr.hit_word = word_of_line(line_rdata[hit_idx], arr.offset);

  // fill empty ways first, pick randomly once the set is full
  assign all_valid  = &valid_vec;
  assign victim_idx = all_valid ? lfsr_q[$bits(way_idx_t)-1:0] : inv_idx;

  // lfsr only advances when a valid line gets evicted
  assign lfsr_step = arr.wr_en & all_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_oh_q <= '0;
      all_valid_q <= 1'b0;
      lfsr_q      <= `ICACHE_LFSR_SEED;
    end else begin
      // victim is frozen once the compare is over
      if (arr.cmp_en) begin
        victim_oh_q <= way_oh_t'(1) << victim_idx;
        all_valid_q <= all_valid;
      end
      // x^8 + x^6 + x^5 + x^4 + 1
      if (lfsr_step) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
    end
  end

  // one line must never sit in two ways of a set
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr.cmp_en |-> $onehot0(hit_oh))
    else $error("icache ways: more than one way hits");

endmodule

/* verilog/icache_ctrl.sv */
// control FSM of the instruction cache, sequences lookups, refills and set clearing
`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_ctrl
  import icache_addr_pkg::*;
  import icache_data_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  // fetch port
  input  logic         req_i,
  input  addr_t        addr_i,
  output logic         ready_o,
  output logic         valid_o,
  output word_t        rdata_o,
  // flush request
  input  logic         flush_i,
  // refill request
  output logic         mem_req_o,
  output addr_t        mem_addr_o,
  input  logic         mem_ack_i,
  // refill return, always consumed
  input  logic         mem_rtrn_vld_i,
  input  line_t        mem_rtrn_line_i,
  // performance counter
  output logic         miss_o,
  icache_array_if.ctrl arr
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e       state_d;
  state_e       state_q;
  // incoming address split into fields
  addr_fields_t req_f;
  // request in compare or refill
  addr_fields_t addr_q;
  logic         accept;
  // flush seen while a request is in flight
  logic         flush_d;
  logic         flush_q;
  // set being cleared
  index_t       flush_cnt_q;
  logic         flush_done;

  assign req_f      = addr_fields_t'(addr_i);
  assign accept     = req_i & ready_o;
  assign flush_done = (flush_cnt_q == index_t'(`ICACHE_SETS - 1));

  ////////////////////
  // main FSM
  ////////////////////

  always_comb begin
    state_d    = state_q;
    flush_d    = flush_q | flush_i;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    mem_req_o  = 1'b0;
    miss_o     = 1'b0;
    arr.rd_en  = 1'b0;
    arr.wr_en  = 1'b0;
    arr.clr_en = 1'b0;
    rdata_o    = arr.hit_word;

    unique case (state_q)
      // clear one set per cycle, later flushes fold into this one
      FLUSH: begin
        arr.clr_en = 1'b1;
        flush_d    = 1'b0;
        if (flush_done) begin
          state_d = IDLE;
        end
      end
      // a request wins over a flush in the same cycle
      IDLE: begin
        ready_o = 1'b1;
        if (req_i) begin
          arr.rd_en = 1'b1;
          state_d   = READ;
        end else if (flush_d) begin
          state_d = FLUSH;
        end
      end
      // arrays answer now
      READ: begin
        if (arr.hit) begin
          valid_o = 1'b1;
          if (flush_d) begin
            state_d = FLUSH;
          end else begin
            // back-to-back hit, read the next set right away
            ready_o = 1'b1;
            state_d = IDLE;
            if (req_i) begin
              arr.rd_en = 1'b1;
              state_d   = READ;
            end
          end
        end else begin
          // hold the refill request until it is taken
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = MISS;
          end
        end
      end
      // forward the word straight from the returning line
      MISS: begin
        rdata_o = word_of_line(mem_rtrn_line_i, addr_q.offset);
        if (mem_rtrn_vld_i) begin
          valid_o   = 1'b1;
          arr.wr_en = 1'b1;
          state_d   = flush_d ? FLUSH : IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////
  // array addressing
  ////////////////////

  // new index on a read, counter while clearing, held request otherwise
  always_comb begin
    if (arr.clr_en) begin
      arr.index = flush_cnt_q;
    end else if (arr.rd_en) begin
      arr.index = req_f.index;
    end else begin
      arr.index = addr_q.index;
    end
  end

  assign arr.cmp_en = (state_q == READ);
  assign arr.tag    = addr_q.tag;
  assign arr.offset = addr_q.offset;
  assign arr.wline  = mem_rtrn_line_i;

  // refills are always whole lines
  assign mem_addr_o = {addr_q.tag, addr_q.index, offset_t'(0)};

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
      // wraps to zero after the last set
      if (arr.clr_en) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= req_f;
    end
  end

  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, READ, MISS})
    else $error("icache ctrl: illegal FSM state");

  // a refill must never land on a set that is being cleared
  wr_clr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(arr.wr_en && arr.clr_en))
    else $error("icache ctrl: refill write during clear");

endmodule

/* verilog/icache_top.sv */
// top level of the instruction cache, connects controller and way arrays to the fetch and refill ports
`timescale 1ns/1ps

module icache_top
  import icache_addr_pkg::*;
  import icache_data_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // fetch request
  input  logic  req_i,
  input  addr_t addr_i,
  output logic  ready_o,
  // fetch response
  output logic  valid_o,
  output word_t rdata_o,
  // clear all lines
  input  logic  flush_i,
  // line refill request
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  input  logic  mem_ack_i,
  // line refill return
  input  logic  mem_rtrn_vld_i,
  input  line_t mem_rtrn_line_i,
  // one pulse per refill
  output logic  miss_o
);

  // controller to ways
  icache_array_if arr_if ();

  icache_ctrl i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .rdata_o         (rdata_o),
    .flush_i         (flush_i),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_line_i (mem_rtrn_line_i),
    .miss_o          (miss_o),
    .arr             (arr_if.ctrl)
  );

  icache_ways i_ways (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (arr_if.ways)
  );

endmodule

/* dv/icache_tb.sv */
// testbench for the instruction cache top, compiled from the file list and run by the build script
`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_tb
  import icache_addr_pkg::*;
  import icache_data_pkg::*;
();

  localparam int WAIT_LIMIT  = 200;
  localparam int RAND_CYCLES = 400;
  localparam int TAG_COUNT   = 1 << $bits(tag_t);
  localparam int WORDS       = `ICACHE_LINE_BITS / `ICACHE_WORD_BITS;
  localparam int EXP_HIT     = 0;
  localparam int EXP_MISS    = 1;
  localparam int EXP_UNKNOWN = 2;

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  req_i;
  addr_t addr_i;
  logic  ready_o;
  logic  valid_o;
  word_t rdata_o;
  logic  flush_i;
  logic  mem_req_o;
  addr_t mem_addr_o;
  logic  mem_ack_i;
  logic  mem_rtrn_vld_i;
  line_t mem_rtrn_line_i;
  logic  miss_o;

  // error counts and event counts
  int          err_data    = 0;
  int          err_ctrl    = 0;
  int          err_timeout = 0;
  int          req_cnt     = 0;
  int          miss_cnt    = 0;
  logic        mem_req_prev = 1'b0;
  word_t       exp_q [$];
  word_t       exp_word;
  logic [31:0] lfsr_state  = 32'h8ee4;

  // responder state, 0 idle, 1 ack pending, 2 return pending
  int          mem_phase = 0;
  int          ack_wait;
  int          rtrn_wait;
  addr_t       refill_addr = '0;
  logic        ack_n;
  logic        vld_n;

  // tags known to sit in each set, valid ways since the last flush
  bit          known   [`ICACHE_SETS][TAG_COUNT];
  int          valid_n [`ICACHE_SETS];
  int          known_n [`ICACHE_SETS];

  icache_top dut (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////
  // helpers
  ////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[31]};
    end
    return v;
  endfunction

  // memory content, every word a fixed mix of its own address
  function automatic word_t word_val(addr_t a);
    addr_t wa;
    wa = {a[`ICACHE_ADDR_BITS-1:2], 2'b00};
    return {wa ^ 16'h5ac3, ~wa} ^ 32'h1357_9bdf;
  endfunction

  // word 0 sits in the low bits of the line
  function automatic line_t line_val(addr_t la);
    line_t l;
    for (int w = 0; w < WORDS; w++) begin
      l[w*`ICACHE_WORD_BITS +: `ICACHE_WORD_BITS] = word_val(la + addr_t'(w * 4));
    end
    return l;
  endfunction

  // 8 tags over sets 3 and 9, so both sets see evictions
  function automatic addr_t pool_addr();
    logic [31:0] r;
    r = rand_bits(6);
    return {1'b0, r[2:0], 4'ha, r[3] ? 4'h9 : 4'h3, r[5:4], 2'b00};
  endfunction

  task automatic finish_run();
    $display("errors: data %0d, control %0d, timeout %0d", err_data, err_ctrl, err_timeout);
    if (err_data + err_ctrl + err_timeout == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    err_timeout++;
    $display("ERROR: timed out at %0t waiting for %s", $time, what);
    finish_run();
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic void model_flush();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      valid_n[s] = 0;
      known_n[s] = 0;
      for (int t = 0; t < TAG_COUNT; t++) begin
        known[s][t] = 1'b0;
      end
    end
  endfunction

  // outcome is only fixed while every valid way of the set is known
  function automatic int expect_kind(addr_t a);
    addr_fields_t f;
    f = addr_fields_t'(a);
    if (known[f.index][f.tag]) begin
      return EXP_HIT;
    end
    if (known_n[f.index] == valid_n[f.index]) begin
      return EXP_MISS;
    end
    return EXP_UNKNOWN;
  endfunction

  function automatic void model_update(addr_t a, logic was_miss);
    addr_fields_t f;
    f = addr_fields_t'(a);
    if (!was_miss) begin
      if (!known[f.index][f.tag]) begin
        known[f.index][f.tag] = 1'b1;
        known_n[f.index]++;
      end
    end else if (valid_n[f.index] < `ICACHE_WAYS) begin
      // an invalid way takes the line, nothing leaves
      known[f.index][f.tag] = 1'b1;
      known_n[f.index]++;
      valid_n[f.index]++;
    end else begin
      // some unknown way was evicted
      for (int t = 0; t < TAG_COUNT; t++) begin
        known[f.index][t] = 1'b0;
      end
      known[f.index][f.tag] = 1'b1;
      known_n[f.index] = 1;
    end
  endfunction

  ////////////////////
  // memory responder
  ////////////////////

  // decide at the falling edge, drive just after the rising edge
  always begin
    @(negedge clk_i);
    ack_n = 1'b0;
    vld_n = 1'b0;
    if (rst_ni) begin
      if (mem_phase == 0 && mem_req_o) begin
        refill_addr = mem_addr_o;
        ack_wait    = rand_bits(2);
        mem_phase   = 1;
        if (mem_addr_o[3:0] != 4'h0) begin
          err_ctrl++;
          $display("FAILED at %0t: refill address %h is not line aligned", $time, mem_addr_o);
        end
      end
      if (mem_phase == 1) begin
        if (!mem_req_o || mem_addr_o !== refill_addr) begin
          err_ctrl++;
          $display("ERROR: refill request dropped or changed before its ack at %0t", $time);
        end
        if (ack_wait == 0) begin
          ack_n     = 1'b1;
          rtrn_wait = rand_bits(2);
          mem_phase = 2;
        end else begin
          ack_wait--;
        end
      end else if (mem_phase == 2) begin
        if (rtrn_wait == 0) begin
          vld_n     = 1'b1;
          mem_phase = 0;
        end else begin
          rtrn_wait--;
        end
      end
    end
    @(posedge clk_i);
    #1;
    mem_ack_i       = ack_n;
    mem_rtrn_vld_i  = vld_n;
    mem_rtrn_line_i = vld_n ? line_val(refill_addr) : '0;
  end

  ////////////////////
  // response monitor
  ////////////////////

  // responses in order of acceptance
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          err_ctrl++;
          $display("ERROR: valid_o at %0t without a pending fetch", $time);
        end else begin
          exp_word = exp_q.pop_front();
          if (rdata_o !== exp_word) begin
            err_data++;
            $display("FAILED at %0t: rdata_o %h, expected %h", $time, rdata_o, exp_word);
          end
        end
      end
      if (req_i && ready_o) begin
        exp_q.push_back(word_val(addr_i));
      end
      if (mem_req_o && !mem_req_prev) begin
        req_cnt++;
      end
      if (miss_o) begin
        miss_cnt++;
        if (!(mem_req_o && mem_ack_i)) begin
          err_ctrl++;
          $display("ERROR: miss_o at %0t outside an acknowledged refill", $time);
        end
      end
      mem_req_prev = mem_req_o;
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////

  // single fetch, hit or miss checked against the model
  task automatic fetch(input addr_t a, output logic was_miss);
    int kind;
    int n;
    int reqs;
    int misses;
    kind   = expect_kind(a);
    reqs   = req_cnt;
    misses = miss_cnt;
    @(posedge clk_i);
    #1;
    req_i  = 1'b1;
    addr_i = a;
    n = 0;
    @(negedge clk_i);
    while (!ready_o) begin
      n++;
      if (n > WAIT_LIMIT) timeout_fail("ready_o with a fetch pending");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    n = 1;
    @(negedge clk_i);
    while (!valid_o) begin
      n++;
      if (n > WAIT_LIMIT) timeout_fail("valid_o");
      @(negedge clk_i);
    end
    was_miss = (req_cnt != reqs);
    if (kind == EXP_HIT && was_miss) begin
      err_ctrl++;
      $display("FAILED at %0t: fetch %h refilled, expected a hit", $time, a);
    end
    if (kind == EXP_MISS && !was_miss) begin
      err_ctrl++;
      $display("FAILED at %0t: fetch %h hit, expected a miss", $time, a);
    end
    if (!was_miss && n != 1) begin
      err_ctrl++;
      $display("FAILED at %0t: hit on %h took %0d cycles", $time, a, n);
    end
    if (was_miss && (refill_addr !== {a[15:4], 4'h0} || !mem_rtrn_vld_i ||
                     miss_cnt != misses + 1)) begin
      err_ctrl++;
      $display("FAILED at %0t: refill of %h had wrong address, timing or miss_o", $time, a);
    end
    model_update(a, was_miss);
  endtask

  // count the cycles with ready_o low
  task automatic check_flush_time();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!ready_o) begin
      n++;
      if (n > WAIT_LIMIT) timeout_fail("ready_o after a flush");
      @(negedge clk_i);
    end
    if (n != `ICACHE_SETS) begin
      err_ctrl++;
      $display("FAILED at %0t: flush kept ready_o low for %0d cycles", $time, n);
    end
  endtask

  task automatic flush_cache();
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    check_flush_time();
    model_flush();
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : main_seq
    logic was_miss;
    logic held;
    int   n;
    int   misses;
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    flush_i         = 1'b0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_line_i = '0;
    model_flush();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    if (ready_o || valid_o || mem_req_o || miss_o) begin
      err_ctrl++;
      $display("FAILED at %0t: outputs not low during reset", $time);
    end
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_flush_time();

    // first fetch misses, then every word of that line hits
    fetch(16'h1234, was_miss);
    for (int w = 0; w < WORDS; w++) begin
      fetch({12'h123, 2'(w), 2'b00}, was_miss);
    end

    // four tags fill set 5 without eviction, then all hit
    flush_cache();
    for (int k = 0; k < `ICACHE_WAYS; k++) begin
      fetch({4'(k + 1), 4'h0, 4'h5, 4'h0}, was_miss);
    end
    for (int k = 0; k < `ICACHE_WAYS; k++) begin
      fetch({4'(k + 1), 4'h0, 4'h5, 2'(k), 2'b00}, was_miss);
    end

    // a fifth tag must push one of them out
    fetch(16'h5050, was_miss);
    misses = 0;
    for (int k = 0; k < `ICACHE_WAYS; k++) begin
      fetch({4'(k + 1), 4'h0, 4'h5, 4'h4}, was_miss);
      if (was_miss) misses++;
    end
    if (misses == 0) begin
      err_ctrl++;
      $display("FAILED at %0t: fifth tag in set 5 evicted none of the others", $time);
    end

    // resident lines are gone after a flush
    fetch(16'h2478, was_miss);
    fetch(16'h247c, was_miss);
    flush_cache();
    fetch(16'h2478, was_miss);
    fetch(16'h1050, was_miss);

    // random back-to-back fetches over a small pool
    repeat (RAND_CYCLES) begin
      @(negedge clk_i);
      held = req_i && !ready_o;
      @(posedge clk_i);
      #1;
      if (!held) begin
        req_i  = (rand_bits(2) != 0);
        addr_i = pool_addr();
      end
    end
    n = 0;
    @(negedge clk_i);
    while (req_i && !ready_o) begin
      n++;
      if (n > WAIT_LIMIT) timeout_fail("the last random fetch to be taken");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n > WAIT_LIMIT) timeout_fail("outstanding responses");
      @(negedge clk_i);
    end

    if (req_cnt != miss_cnt) begin
      err_ctrl++;
      $display("FAILED at %0t: %0d refills but %0d miss_o pulses", $time, req_cnt, miss_cnt);
    end
    finish_run();
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/icache_addr_pkg.sv
verilog/icache_data_pkg.sv
verilog/icache_array_if.sv
verilog/icache_sram.sv
verilog/icache_ways.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
dv/icache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it and look for the pass line in its output
verilator --binary --timing --assert -f sources.f --top-module icache_tb || exit 1
out=$(./obj_dir/Vicache_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "PASS: all tests" \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
